/* list.f */
design/fetch_pkg.sv
design/scratch_fetch_mem.sv
design/icache.sv
design/fetch.sv
design/fetch_buffer.sv
design/fetch_top.sv
tb/fetch_assert.sv
tb/fetch_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module fetch_tb -f list.f -o fetch_sim &&
./obj_dir/fetch_sim +verilator+error+limit+1000 ||
exit 1

/* tb/fetch_tb.sv */
// Testbench for the instruction fetch stage.
// Loads the scratch memory, answers refills from a memory model and
// drives flushes and decode pops. The bound assertion module checks.

`timescale 1ns/1ns
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int ROUNDS = 24;
    localparam int MAX_RUN = 40;
    localparam int MAX_WAIT = 30;
    localparam logic [31:0] WORD_KEY = 32'hA5A5_0000;
    // Upper bound on the length of all phases, in cycles
    localparam int PHASE_CYCLES =
        4 + SCRATCH_WORDS + 2 + ROUNDS * (MAX_RUN + MAX_WAIT + 14) + 120;

    logic         clk;
    logic         rst;
    logic         flush;
    logic [31:0]  flush_pc;
    logic         scratch_we;
    logic [31:0]  scratch_addr;
    logic [31:0]  scratch_wdata;
    logic         mem_req;
    logic [31:0]  mem_addr;
    logic         mem_rvalid = 1'b0;
    logic [31:0]  mem_rdata = '0;
    logic         decode_pop;
    logic         decode_valid;
    fetch_entry_t decode_entry;

    logic refill_busy = 1'b0;
    int   refill_wait = 0;
    int   refills = 0;
    int   miss_flushes = 0;
    int   pops = 0;
    int   seed_val;

    fetch_top uut (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .flush_pc      (flush_pc),
        .scratch_we    (scratch_we),
        .scratch_addr  (scratch_addr),
        .scratch_wdata (scratch_wdata),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_rvalid    (mem_rvalid),
        .mem_rdata     (mem_rdata),
        .decode_pop    (decode_pop),
        .decode_valid  (decode_valid),
        .decode_entry  (decode_entry)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return addr ^ WORD_KEY;
    endfunction

    function automatic logic pick_pop(input int pct);
        return int'($urandom_range(99, 0)) < pct;
    endfunction

    function automatic logic [31:0] scratch_target();
        return SCRATCH_BASE + (32'($urandom_range(127, 0)) << 2);
    endfunction

    function automatic logic [31:0] cache_target();
        return 32'($urandom_range(255, 0)) << 2;
    endfunction

    function automatic int round_pop_pct(input int r);
        case (r % 4)
            0: return 75;
            1: return 100;
            2: return 0;
            default: return 40;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    //////////////////////////////
    // Refill memory, answers after 1 to 6 cycles
    always @(negedge clk) begin
        if (rst) begin
            mem_rvalid = 1'b0;
            refill_busy = 1'b0;
        end else if (mem_rvalid) begin
            mem_rvalid = 1'b0;
        end else if (mem_req) begin
            if (!refill_busy) begin
                refill_busy = 1'b1;
                refill_wait = int'($urandom_range(6, 1));
                refills++;
            end
            if (refill_wait == 1) begin
                mem_rvalid = 1'b1;
                mem_rdata = expected_word(mem_addr);
                refill_busy = 1'b0;
            end else begin
                refill_wait--;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && decode_pop && decode_valid && !flush) begin
            pops++;
        end
    end

    //////////////////////////////
    // Stimulus helpers
    task automatic run_cycles(input int n, input int pop_pct);
        repeat (n) begin
            @(negedge clk);
            decode_pop = pick_pop(pop_pct);
        end
    endtask

    // Called at a falling edge, holds flush for one cycle
    task automatic flush_now(input logic [31:0] target);
        if (mem_req) begin
            miss_flushes++;
        end
        flush = 1'b1;
        flush_pc = target;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic do_flush(input logic [31:0] target);
        @(negedge clk);
        flush_now(target);
    endtask

    task automatic wait_refill(input int max_cycles, input int pop_pct);
        int n;
        n = 0;
        while (!mem_req && n < max_cycles) begin
            @(negedge clk);
            decode_pop = pick_pop(pop_pct);
            n++;
        end
    endtask

    task automatic load_scratch();
        logic [31:0] addr;
        for (int i = 0; i < SCRATCH_WORDS; i++) begin
            @(negedge clk);
            addr = SCRATCH_BASE + 32'(i * 4);
            scratch_we = 1'b1;
            scratch_addr = addr;
            scratch_wdata = expected_word(addr);
            decode_pop = pick_pop(50);
        end
        @(negedge clk);
        scratch_we = 1'b0;
    endtask

    //////////////////////////////
    // Phases
    initial begin
        logic [31:0] target;
        int pop_pct;
        seed_val = $urandom(13);
        rst = 1'b1;
        flush = 1'b0;
        flush_pc = '0;
        scratch_we = 1'b0;
        scratch_addr = '0;
        scratch_wdata = '0;
        decode_pop = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // Fetch streams the cached region from the reset vector meanwhile
        load_scratch();

        for (int r = 0; r < ROUNDS; r++) begin
            pop_pct = round_pop_pct(r);
            run_cycles(int'($urandom_range(MAX_RUN, 10)), pop_pct);
            if (r % 2 == 0) begin
                target = cache_target();
                do_flush(target);
                if (r % 8 == 4) begin
                    // Jump back so the first words hit
                    run_cycles(8, 100);
                    do_flush(target);
                end
            end else begin
                // Last target was cached, try to land on a refill
                wait_refill(MAX_WAIT, pop_pct);
                flush_now(scratch_target());
            end
        end

        // Back-pressure in both regions
        do_flush(scratch_target());
        run_cycles(20, 0);
        run_cycles(12, 100);
        do_flush(cache_target());
        run_cycles(40, 0);
        run_cycles(30, 100);
        run_cycles(4, 0);

        if (uut.checks.failed) begin
            fail_run("a fetch assertion failed");
        end else if (miss_flushes == 0) begin
            fail_run("no flush landed during an outstanding refill");
        end else if (refills == 0 || pops == 0) begin
            fail_run("the stimulus produced no refill or no pop");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

    initial begin
        wait (uut.checks.failed == 1'b1);
        fail_run("a fetch assertion failed, see the error above");
    end

    // Watchdog
    initial begin
        #(PHASE_CYCLES * 20 * CLK_PERIOD);
        fail_run("watchdog timeout, the test phases did not finish");
    end

endmodule

`default_nettype wire

/* tb/fetch_assert.sv */
// Concurrent checks on the fetch stage, bound into fetch_top.
// A failing property raises failed, which the testbench watches.

`timescale 1ns/1ns
`default_nettype none

module fetch_assert
    import fetch_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         flush,
    input logic [31:0]  flush_pc,
    input logic         mem_req,
    input logic [31:0]  mem_addr,
    input logic         mem_rvalid,
    input logic         decode_pop,
    input logic         decode_valid,
    input fetch_entry_t decode_entry,
    input logic         push,
    input fetch_entry_t push_entry
);

    localparam logic [31:0] WORD_KEY = 32'hA5A5_0000;

    logic failed = 1'b0;
    logic pop_fire;
    logic redirect_pending;
    logic [31:0] expect_pc;
    logic refill_flushed;

    assign pop_fire = decode_pop & decode_valid & ~flush;

    // PC of the next popped entry
    always_ff @(posedge clk) begin
        if (rst) begin
            expect_pc <= RESET_VEC;
            redirect_pending <= 1'b1;
        end else if (flush) begin
            expect_pc <= {flush_pc[31:2], 2'b00};
            redirect_pending <= 1'b1;
        end else if (pop_fire) begin
            expect_pc <= decode_entry.pc + 32'd4;
            redirect_pending <= 1'b0;
        end
    end

    // Flush from the miss cycle up to the refill word
    always_ff @(posedge clk) begin
        if (rst) begin
            refill_flushed <= 1'b0;
        end else if (!mem_req) begin
            refill_flushed <= flush;
        end else if (flush) begin
            refill_flushed <= 1'b1;
        end
    end

    //////////////////////////////
    reset_quiet: assert property (@(posedge clk)
        rst |=> !decode_valid && !mem_req && !push)
        else begin failed = 1'b1; $error("** Error @ %0t: output active in reset", $time); end

    word_rule: assert property (@(posedge clk) disable iff (rst)
        decode_valid |-> decode_entry.instruction == (decode_entry.pc ^ WORD_KEY))
        else begin failed = 1'b1; $error("** Error @ %0t: word does not match pc", $time); end

    pc_sequence: assert property (@(posedge clk) disable iff (rst)
        pop_fire && !redirect_pending |-> decode_entry.pc == expect_pc)
        else begin failed = 1'b1; $error("** Error @ %0t: pc out of sequence", $time); end

    redirect_pc: assert property (@(posedge clk) disable iff (rst)
        pop_fire && redirect_pending |-> decode_entry.pc == expect_pc)
        else begin failed = 1'b1; $error("** Error @ %0t: wrong pc after redirect", $time); end

    refill_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_rvalid |=> mem_req && $stable(mem_addr))
        else begin failed = 1'b1; $error("** Error @ %0t: refill request dropped", $time); end

    refill_return: assert property (@(posedge clk) disable iff (rst)
        $fell(mem_req) && !refill_flushed && !flush |-> push && push_entry.pc == $past(mem_addr))
        else begin failed = 1'b1; $error("** Error @ %0t: refill word not pushed", $time); end

    head_stable: assert property (@(posedge clk) disable iff (rst)
        decode_valid && !decode_pop && !flush |=> decode_valid && $stable(decode_entry))
        else begin failed = 1'b1; $error("** Error @ %0t: head moved without pop", $time); end

endmodule

bind fetch_top fetch_assert checks (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .flush_pc     (flush_pc),
    .mem_req      (mem_req),
    .mem_addr     (mem_addr),
    .mem_rvalid   (mem_rvalid),
    .decode_pop   (decode_pop),
    .decode_valid (decode_valid),
    .decode_entry (decode_entry),
    .push         (push),
    .push_entry   (push_entry)
);

`default_nettype wire

/* design/fetch_top.sv */
// Top of the instruction fetch stage.
// Connects the fetch unit to the pre-decode buffer and exposes the
// flush, scratch load, refill and decode ports.

`timescale 1ns/1ns
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic [31:0]  flush_pc,
    input  logic         scratch_we,
    input  logic [31:0]  scratch_addr,
    input  logic [31:0]  scratch_wdata,
    output logic         mem_req,
    output logic [31:0]  mem_addr,
    input  logic         mem_rvalid,
    input  logic [31:0]  mem_rdata,
    input  logic         decode_pop,
    output logic         decode_valid,
    output fetch_entry_t decode_entry
);

    logic         push;
    fetch_entry_t push_entry;

    fetch fetch_unit (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .flush_pc      (flush_pc),
        .scratch_we    (scratch_we),
        .scratch_addr  (scratch_addr),
        .scratch_wdata (scratch_wdata),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_rvalid    (mem_rvalid),
        .mem_rdata     (mem_rdata),
        .decode_pop    (decode_pop),
        .push          (push),
        .entry         (push_entry)
    );

    fetch_buffer pre_decode (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .push       (push),
        .push_entry (push_entry),
        .pop        (decode_pop),
        .valid      (decode_valid),
        .head       (decode_entry)
    );

endmodule

`default_nettype wire

/* design/fetch_buffer.sv */
// Pre-decode buffer between fetch and decode.
// Circular FIFO of fetch entries. Fetch only pushes when it holds a
// credit, so every push is accepted. A flush empties the buffer.

`timescale 1ns/1ns
`default_nettype none

module fetch_buffer
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic         push,
    input  fetch_entry_t push_entry,
    input  logic         pop,
    output logic         valid,
    output fetch_entry_t head
);

    fetch_entry_t slots [FETCH_BUFFER_DEPTH];
    logic [FB_PTR_W-1:0] wr_ptr;
    logic [FB_PTR_W-1:0] rd_ptr;
    logic [CREDIT_W-1:0] count;
    logic do_pop;

    // Wraps for any depth
    function automatic logic [FB_PTR_W-1:0] next_ptr(input logic [FB_PTR_W-1:0] ptr);
        if (int'(ptr) == FETCH_BUFFER_DEPTH - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign valid = count != '0;
    assign do_pop = pop & valid;
    assign head = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst | flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CREDIT_W'(push) - CREDIT_W'(do_pop);
        end
    end

endmodule

`default_nettype wire

/* design/fetch.sv */
// Instruction fetch stage.
// Holds the PC, steers each request to the scratch memory or the
// cache, and pushes returned words with their PC into the pre-decode
// buffer. Credits make sure every issued word has a buffer slot.

`timescale 1ns/1ns
`default_nettype none

module fetch
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic [31:0]  flush_pc,
    input  logic         scratch_we,
    input  logic [31:0]  scratch_addr,
    input  logic [31:0]  scratch_wdata,
    output logic         mem_req,
    output logic [31:0]  mem_addr,
    input  logic         mem_rvalid,
    input  logic [31:0]  mem_rdata,
    input  logic         decode_pop,
    output logic         push,
    output fetch_entry_t entry
);

    logic [31:0] pc;
    logic [31:0] fetch_addr;
    logic [31:0] stage2_pc;

    logic [NUM_UNITS-1:0] unit_match;
    logic [NUM_UNITS-1:0] unit_request;
    logic [NUM_UNITS-1:0] unit_ready;
    logic [NUM_UNITS-1:0] unit_dv;
    logic [31:0] unit_data [NUM_UNITS];
    logic [31:0] merged;

    logic units_ready;
    logic issue;
    logic [CREDIT_W-1:0] credits;
    logic inflight;
    logic buffer_has_word;
    logic credit_return;
    logic cache_pending;
    logic discard;

    //////////////////////////////
    // PC and request address
    // A flush issues straight from flush_pc in the same cycle
    assign fetch_addr = flush ? {flush_pc[31:2], 2'b00} : pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VEC;
        end else if (issue) begin
            pc <= fetch_addr + 32'd4;
        end else if (flush) begin
            pc <= fetch_addr;
        end
    end

    // Region decode
    assign unit_match[UNIT_SCRATCH] =
        fetch_addr[31 -: SCRATCH_BIT_CHECK] == SCRATCH_BASE[31 -: SCRATCH_BIT_CHECK];
    assign unit_match[UNIT_ICACHE] = ~unit_match[UNIT_SCRATCH];

    assign units_ready = &unit_ready;
    assign issue = units_ready & (credits != '0) & ~rst;
    assign unit_request = unit_match & {NUM_UNITS{issue}};

    always_ff @(posedge clk) begin
        if (issue) begin
            stage2_pc <= fetch_addr;
        end
    end

    //////////////////////////////
    // Credits
    // At most one word is between issue and return, so free credits plus
    // the in-flight word tell whether the buffer holds anything to pop
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight <= 1'b0;
        end else if (issue) begin
            inflight <= 1'b1;
        end else if (flush | (|unit_dv)) begin
            inflight <= 1'b0;
        end
    end

    assign buffer_has_word = (int'(credits) + int'(inflight)) < FETCH_BUFFER_DEPTH;
    assign credit_return = decode_pop & buffer_has_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_W'(FETCH_BUFFER_DEPTH);
        end else if (flush) begin
            credits <= CREDIT_W'(FETCH_BUFFER_DEPTH) - CREDIT_W'(issue);
        end else begin
            credits <= credits - CREDIT_W'(issue) + CREDIT_W'(credit_return);
        end
    end

    //////////////////////////////
    // Late flush discard
    // Cache request not yet answered
    always_ff @(posedge clk) begin
        if (rst) begin
            cache_pending <= 1'b0;
        end else if (unit_request[UNIT_ICACHE]) begin
            cache_pending <= 1'b1;
        end else if (unit_dv[UNIT_ICACHE]) begin
            cache_pending <= 1'b0;
        end
    end

    // A miss caught by a flush still returns, drop that word
    always_ff @(posedge clk) begin
        if (rst) begin
            discard <= 1'b0;
        end else if (flush & cache_pending & ~unit_dv[UNIT_ICACHE]) begin
            discard <= 1'b1;
        end else if (unit_dv[UNIT_ICACHE]) begin
            discard <= 1'b0;
        end
    end

    //////////////////////////////
    // Sub-units
    scratch_fetch_mem scratch_mem (
        .clk         (clk),
        .new_request (unit_request[UNIT_SCRATCH]),
        .addr        (fetch_addr),
        .we          (scratch_we),
        .waddr       (scratch_addr),
        .wdata       (scratch_wdata),
        .ready       (unit_ready[UNIT_SCRATCH]),
        .data_valid  (unit_dv[UNIT_SCRATCH]),
        .data        (unit_data[UNIT_SCRATCH])
    );

    icache i_cache (
        .clk         (clk),
        .rst         (rst),
        .new_request (unit_request[UNIT_ICACHE]),
        .addr        (fetch_addr),
        .ready       (unit_ready[UNIT_ICACHE]),
        .data_valid  (unit_dv[UNIT_ICACHE]),
        .data        (unit_data[UNIT_ICACHE]),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata)
    );

    // Mask each word with its valid and OR them together
    always_comb begin
        merged = '0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            merged |= unit_data[i] & {32{unit_dv[i]}};
        end
    end

    assign push = (|unit_dv) & ~flush & ~discard;
    assign entry.instruction = merged;
    assign entry.pc = stage2_pc;

endmodule

`default_nettype wire

/* design/icache.sv */
// Direct-mapped instruction cache with one-word lines.
// A hit returns its word one cycle after the request. A miss drops
// ready, refills the word over the memory port and then returns it.
// Only one refill is outstanding at any time.

`timescale 1ns/1ns
`default_nettype none

module icache
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        new_request,
    input  logic [31:0] addr,
    output logic        ready,
    output logic        data_valid,
    output logic [31:0] data,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    input  logic        mem_rvalid,
    input  logic [31:0] mem_rdata
);

    //////////////////////////////
    // Line storage
    logic [ICACHE_TAG_W-1:0] tag_arr [ICACHE_LINES];
    logic [31:0] data_arr [ICACHE_LINES];
    logic [ICACHE_LINES-1:0] valid_arr;

    // Request captured for the lookup stage
    logic [ICACHE_INDEX_W-1:0] req_index;
    logic [ICACHE_TAG_W-1:0] req_tag;
    logic stage_req;

    logic hit;
    logic miss;
    logic miss_active;
    logic fill_write;
    logic fill_done;

    //////////////////////////////
    // Request stage
    always_ff @(posedge clk) begin
        if (new_request) begin
            req_index <= addr[ICACHE_INDEX_W+1:2];
            req_tag <= addr[31:ICACHE_INDEX_W+2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_req <= 1'b0;
        end else begin
            stage_req <= new_request;
        end
    end

    // Tag compare in the cycle after the request
    assign hit = valid_arr[req_index] & (tag_arr[req_index] == req_tag);
    assign miss = stage_req & ~hit;

    //////////////////////////////
    // Refill controller
    // Index and tag stay put during a refill since no request can
    // arrive while ready is low
    assign fill_write = miss_active & mem_rvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            miss_active <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            if (miss) begin
                miss_active <= 1'b1;
            end else if (fill_write) begin
                miss_active <= 1'b0;
            end
            fill_done <= fill_write;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '0;
        end else if (fill_write) begin
            valid_arr[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_write) begin
            tag_arr[req_index] <= req_tag;
            data_arr[req_index] <= mem_rdata;
        end
    end

    assign mem_req = miss_active;
    assign mem_addr = {req_tag, req_index, 2'b00};

    //////////////////////////////
    // Return path
    // Low from the miss cycle until the refill word is back
    assign ready = ~(miss | miss_active);

    assign data_valid = (stage_req & hit) | fill_done;

    // Staged line serves a hit and the word just filled
    assign data = data_arr[req_index];

endmodule

`default_nettype wire

/* design/scratch_fetch_mem.sv */
// Scratch instruction memory for the fetch stage.
// Reads take exactly one cycle and the unit is always ready.
// A separate write port loads the program before or during a run.

`timescale 1ns/1ns
`default_nettype none

module scratch_fetch_mem
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        new_request,
    input  logic [31:0] addr,
    input  logic        we,
    input  logic [31:0] waddr,
    input  logic [31:0] wdata,
    output logic        ready,
    output logic        data_valid,
    output logic [31:0] data
);

    logic [31:0] mem [SCRATCH_WORDS];
    logic [SCRATCH_ADDR_W-1:0] rd_index;
    logic [SCRATCH_ADDR_W-1:0] wr_index;

    // Word addressed, byte offset ignored
    assign rd_index = addr[SCRATCH_ADDR_W+1:2];
    assign wr_index = waddr[SCRATCH_ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_index] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (new_request) begin
            data <= mem[rd_index];
        end
        data_valid <= new_request;
    end

    // Fixed latency, never stalls
    assign ready = 1'b1;

endmodule

`default_nettype wire

/* design/fetch_pkg.sv */
// Shared constants and types for the instruction fetch stage.
// Holds the address map, memory sizes, reset vector and the entry
// type carried from fetch into the pre-decode buffer.

`default_nettype none

package fetch_pkg;

    //////////////////////////////
    // Address map
    localparam logic [31:0] RESET_VEC = 32'h0000_0100;
    localparam logic [31:0] SCRATCH_BASE = 32'h8000_0000;

    // Upper address bits compared against SCRATCH_BASE
    localparam int SCRATCH_BIT_CHECK = 1;

    //////////////////////////////
    // Sizes
    localparam int SCRATCH_WORDS = 256;
    localparam int ICACHE_LINES = 16;
    localparam int FETCH_BUFFER_DEPTH = 4;

    // Derived widths
    localparam int SCRATCH_ADDR_W = $clog2(SCRATCH_WORDS);
    localparam int ICACHE_INDEX_W = $clog2(ICACHE_LINES);
    localparam int ICACHE_TAG_W = 30 - ICACHE_INDEX_W;
    localparam int FB_PTR_W = $clog2(FETCH_BUFFER_DEPTH);
    localparam int CREDIT_W = FB_PTR_W + 1;

    // Fetch sub-unit slots
    localparam int NUM_UNITS = 2;
    localparam int UNIT_SCRATCH = 0;
    localparam int UNIT_ICACHE = 1;

    // One pre-decode buffer slot
    typedef struct packed {
        logic [31:0] instruction;
        logic [31:0] pc;
    } fetch_entry_t;

endpackage

`default_nettype wire
